// File: a2_card_cfg.svh
// ====================
// Build-time widths, levels and enable defaults for the card glue logic
// Included by the package and by every RTL module that needs a constant
// ====================
`ifndef A2_CARD_CFG_SVH
`define A2_CARD_CFG_SVH

// Bus, audio and video widths
`define A2_DATA_W 8
`define AUDIO_W 16
`define MB_LEVEL_W 10
`define COLOR_W 8
`define COORD_W 10

// Speaker square wave magnitude
`define SPEAKER_LEVEL 16'h3000

// Equal synchronized samples before a new clock level is accepted
`define DENOISE_SAMPLES 3

// Feature defaults
`define SCANLINES_DEFAULT 1'b0
`define BUS_DATA_OUT_DEFAULT 1'b1
`define IRQ_OUT_DEFAULT 1'b1

`endif

// File: a2_card_pkg.sv
// ====================
// Shared types for the card glue logic
// ====================
`include "a2_card_cfg.svh"

package a2_card_pkg;

    // Apple data bus byte
    typedef logic [`A2_DATA_W-1:0] a2_data_t;

    // Audio word, signedness depends on the source
    typedef logic [`AUDIO_W-1:0] audio_sample_t;

    // Raw Mockingboard channel level, unsigned
    typedef logic [`MB_LEVEL_W-1:0] mb_level_t;

    // One colour channel
    typedef logic [`COLOR_W-1:0] color_t;

    // Screen row or column
    typedef logic [`COORD_W-1:0] screen_coord_t;

    // Accepted level of a filtered Apple clock
    typedef enum logic {
        LEVEL_LOW  = 1'b0,
        LEVEL_HIGH = 1'b1
    } clk_level_t;

endpackage

// File: a2_clock_sync.sv
// ====================
// Brings one Apple clock into the logic domain with a glitch filter
// Gives a clean level, its inverse and one-cycle edge pulses
// ====================
`timescale 1ns/1ns
`include "a2_card_cfg.svh"

module a2_clock_sync (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic clk_i,
    output logic level_o,
    output logic level_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    import a2_card_pkg::*;

    localparam int CNT_W = $clog2(`DENOISE_SAMPLES + 1);
    localparam logic [CNT_W-1:0] LAST_SAMPLE = CNT_W'(`DENOISE_SAMPLES - 1);

    logic [1:0] sync_r;
    clk_level_t state_r;
    logic [CNT_W-1:0] count_r;
    logic sample_differs_w;

    // Synchronized input disagrees with the accepted level
    assign sample_differs_w = sync_r[1] != (state_r == LEVEL_HIGH);

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            sync_r <= 2'b00;
            state_r <= LEVEL_LOW;
            count_r <= '0;
            posedge_o <= 1'b0;
            negedge_o <= 1'b0;
        end else begin
            sync_r <= {sync_r[0], clk_i};
            posedge_o <= 1'b0;
            negedge_o <= 1'b0;

            if (sample_differs_w) begin
                if (count_r == LAST_SAMPLE) begin
                    // Enough equal samples, flip the level
                    count_r <= '0;
                    case (state_r)
                        LEVEL_LOW: begin
                            state_r <= LEVEL_HIGH;
                            posedge_o <= 1'b1;
                        end
                        default: begin
                            state_r <= LEVEL_LOW;
                            negedge_o <= 1'b1;
                        end
                    endcase
                end else begin
                    count_r <= count_r + 1'b1;
                end
            end else begin
                // A glitch back to the current level restarts the count
                count_r <= '0;
            end
        end
    end

    assign level_o = (state_r == LEVEL_HIGH);
    assign level_n_o = ~level_o;

    // Edge pulses are mutually exclusive and match the new level
    edge_pulses_exclusive: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        !(posedge_o && negedge_o)
    ) else $error("a2_clock_sync: posedge and negedge pulses together");

endmodule

// File: bus_data_select.sv
// ====================
// Picks the byte the slot cards return to the Apple bus, by priority
// Also merges the card interrupts into one active-low line
// ====================
`timescale 1ns/1ns
`include "a2_card_cfg.svh"

module bus_data_select #(
    parameter bit DATA_OUT_ENABLE = `BUS_DATA_OUT_DEFAULT,
    parameter bit IRQ_OUT_ENABLE = `IRQ_OUT_DEFAULT
) (
    input  logic clk_logic_w,
    input  logic reset_i,

    input  a2_card_pkg::a2_data_t bus_data_i,

    input  logic ssc_rd_i,
    input  a2_card_pkg::a2_data_t ssc_data_i,
    input  logic ssp_rd_i,
    input  a2_card_pkg::a2_data_t ssp_data_i,
    input  logic mb_rd_i,
    input  a2_card_pkg::a2_data_t mb_data_i,

    input  logic ssc_irq_n_i,
    input  logic ssp_irq_n_i,
    input  logic mb_irq_n_i,

    output logic data_out_en_o,
    output a2_card_pkg::a2_data_t data_out_o,
    output logic irq_n_o
);

    import a2_card_pkg::*;

    a2_data_t data_sel_w;
    logic any_rd_w;
    logic irq_n_w;

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // Serial card wins, then SuperSprite, then Mockingboard
    always_comb begin
        if (ssc_rd_i) begin
            data_sel_w = ssc_data_i;
        end else if (ssp_rd_i) begin
            data_sel_w = ssp_data_i;
        end else if (mb_rd_i) begin
            data_sel_w = mb_data_i;
        end else begin
            // Nobody reads, keep what is on the bus
            data_sel_w = bus_data_i;
        end
    end

    assign irq_n_w = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            data_out_en_o <= 1'b0;
            data_out_o <= '0;
            irq_n_o <= 1'b1;
        end else begin
            data_out_en_o <= any_rd_w & DATA_OUT_ENABLE;
            data_out_o <= data_sel_w;
            irq_n_o <= IRQ_OUT_ENABLE ? irq_n_w : 1'b1;
        end
    end

    // The bus is only driven after a card asked to be read
    no_drive_without_read: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        !any_rd_w |=> !data_out_en_o
    ) else $error("bus_data_select: data driven with no read request");

endmodule

// File: audio_mixer.sv
// ====================
// Two-stage audio mix: each source is made signed, then all are summed
// Output follows the inputs two clocks later, wrapping at 16 bits
// ====================
`timescale 1ns/1ns
`include "a2_card_cfg.svh"

module audio_mixer (
    input  logic clk_logic_w,
    input  logic reset_i,

    input  a2_card_pkg::audio_sample_t ensoniq_l_i,
    input  a2_card_pkg::audio_sample_t ensoniq_r_i,
    input  a2_card_pkg::audio_sample_t ssp_audio_i,
    input  a2_card_pkg::mb_level_t mb_l_i,
    input  a2_card_pkg::mb_level_t mb_r_i,
    input  logic speaker_i,
    input  logic speaker_sw_n_i,

    output a2_card_pkg::audio_sample_t mix_l_o,
    output a2_card_pkg::audio_sample_t mix_r_o
);

    import a2_card_pkg::*;

    // Places the Mockingboard level just under the sign bit
    localparam int MB_SHIFT = `AUDIO_W - 1 - `MB_LEVEL_W;
    localparam audio_sample_t MID_SCALE = {1'b1, {(`AUDIO_W-1){1'b0}}};
    localparam audio_sample_t SPK_HIGH = `SPEAKER_LEVEL;
    localparam audio_sample_t SPK_LOW = '0 - SPK_HIGH;

    audio_sample_t ens_l_r;
    audio_sample_t ens_r_r;
    audio_sample_t ssp_r;
    audio_sample_t mb_l_r;
    audio_sample_t mb_r_r;
    audio_sample_t spk_r;
    audio_sample_t spk_w;

    // Speaker square wave, silent unless the switch is on
    always_comb begin
        if (!speaker_sw_n_i) begin
            spk_w = speaker_i ? SPK_HIGH : SPK_LOW;
        end else begin
            spk_w = '0;
        end
    end

    // Stage 1, convert to signed
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            ens_l_r <= '0;
            ens_r_r <= '0;
            ssp_r <= '0;
            mb_l_r <= '0;
            mb_r_r <= '0;
            spk_r <= '0;
        end else begin
            ens_l_r <= ensoniq_l_i;
            ens_r_r <= ensoniq_r_i;
            ssp_r <= ssp_audio_i - MID_SCALE;
            mb_l_r <= (audio_sample_t'(mb_l_i) << MB_SHIFT) - MID_SCALE;
            mb_r_r <= (audio_sample_t'(mb_r_i) << MB_SHIFT) - MID_SCALE;
            spk_r <= spk_w;
        end
    end

    // Stage 2, per-channel sum
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            mix_l_o <= '0;
            mix_r_o <= '0;
        end else begin
            mix_l_o <= ens_l_r + ssp_r + mb_l_r + spk_r;
            mix_r_o <= ens_r_r + ssp_r + mb_r_r + spk_r;
        end
    end

endmodule

// File: scanline_dimmer.sv
// ====================
// Halves the pixel colour on odd rows when scanlines are on
// ====================
`timescale 1ns/1ns
`include "a2_card_cfg.svh"

module scanline_dimmer (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  a2_card_pkg::color_t r_i,
    input  a2_card_pkg::color_t g_i,
    input  a2_card_pkg::color_t b_i,
    input  a2_card_pkg::screen_coord_t screen_y_i,
    input  logic scanline_sw_n_i,
    output a2_card_pkg::color_t r_o,
    output a2_card_pkg::color_t g_o,
    output a2_card_pkg::color_t b_o
);

    logic scanlines_en_w;
    logic dim_w;

    assign scanlines_en_w = `SCANLINES_DEFAULT | ~scanline_sw_n_i;
    // Odd rows only
    assign dim_w = scanlines_en_w & screen_y_i[0];

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            r_o <= '0;
            g_o <= '0;
            b_o <= '0;
        end else begin
            r_o <= dim_w ? (r_i >> 1) : r_i;
            g_o <= dim_w ? (g_i >> 1) : g_i;
            b_o <= dim_w ? (b_i >> 1) : b_i;
        end
    end

endmodule

// File: a2_card_top.sv
// ====================
// Card glue top level: clock recovery, bus return path, audio mix, scanlines
// Card, audio and video cores sit outside and feed the inputs here
// ====================
`timescale 1ns/1ns

module a2_card_top (
    input  logic clk_logic_w,
    input  logic reset_i,

    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    input  logic [3:0] dip_switches_n_i,

    input  a2_card_pkg::a2_data_t bus_data_i,
    input  logic ssc_rd_i,
    input  a2_card_pkg::a2_data_t ssc_data_i,
    input  logic ssp_rd_i,
    input  a2_card_pkg::a2_data_t ssp_data_i,
    input  logic mb_rd_i,
    input  a2_card_pkg::a2_data_t mb_data_i,
    input  logic ssc_irq_n_i,
    input  logic ssp_irq_n_i,
    input  logic mb_irq_n_i,

    input  a2_card_pkg::audio_sample_t ensoniq_l_i,
    input  a2_card_pkg::audio_sample_t ensoniq_r_i,
    input  a2_card_pkg::audio_sample_t ssp_audio_i,
    input  a2_card_pkg::mb_level_t mb_l_i,
    input  a2_card_pkg::mb_level_t mb_r_i,
    input  logic speaker_i,

    input  a2_card_pkg::color_t r_i,
    input  a2_card_pkg::color_t g_i,
    input  a2_card_pkg::color_t b_i,
    input  a2_card_pkg::screen_coord_t screen_y_i,

    output logic phi0_o,
    output logic phi1_o,
    output logic phi1_posedge_o,
    output logic phi1_negedge_o,
    output logic clk_7m_o,
    output logic clk_7m_posedge_o,
    output logic clk_7m_negedge_o,

    output logic data_out_en_o,
    output a2_card_pkg::a2_data_t data_out_o,
    output logic irq_n_o,

    output a2_card_pkg::audio_sample_t mix_l_o,
    output a2_card_pkg::audio_sample_t mix_r_o,

    output a2_card_pkg::color_t r_o,
    output a2_card_pkg::color_t g_o,
    output a2_card_pkg::color_t b_o
);

    // Phi0 is the filtered inverse of phi1
    a2_clock_sync phi1_sync (
        .clk_logic_w(clk_logic_w),
        .reset_i(reset_i),
        .clk_i(a2_phi1_i),
        .level_o(phi1_o),
        .level_n_o(phi0_o),
        .posedge_o(phi1_posedge_o),
        .negedge_o(phi1_negedge_o)
    );

    a2_clock_sync clk_7m_sync (
        .clk_logic_w(clk_logic_w),
        .reset_i(reset_i),
        .clk_i(a2_7m_i),
        .level_o(clk_7m_o),
        .level_n_o(),
        .posedge_o(clk_7m_posedge_o),
        .negedge_o(clk_7m_negedge_o)
    );

    bus_data_select bus_data_select (
        .clk_logic_w(clk_logic_w),
        .reset_i(reset_i),
        .bus_data_i(bus_data_i),
        .ssc_rd_i(ssc_rd_i),
        .ssc_data_i(ssc_data_i),
        .ssp_rd_i(ssp_rd_i),
        .ssp_data_i(ssp_data_i),
        .mb_rd_i(mb_rd_i),
        .mb_data_i(mb_data_i),
        .ssc_irq_n_i(ssc_irq_n_i),
        .ssp_irq_n_i(ssp_irq_n_i),
        .mb_irq_n_i(mb_irq_n_i),
        .data_out_en_o(data_out_en_o),
        .data_out_o(data_out_o),
        .irq_n_o(irq_n_o)
    );

    // Dip switch 1 enables the speaker
    audio_mixer audio_mixer (
        .clk_logic_w(clk_logic_w),
        .reset_i(reset_i),
        .ensoniq_l_i(ensoniq_l_i),
        .ensoniq_r_i(ensoniq_r_i),
        .ssp_audio_i(ssp_audio_i),
        .mb_l_i(mb_l_i),
        .mb_r_i(mb_r_i),
        .speaker_i(speaker_i),
        .speaker_sw_n_i(dip_switches_n_i[1]),
        .mix_l_o(mix_l_o),
        .mix_r_o(mix_r_o)
    );

    // Dip switch 0 enables scanlines
    scanline_dimmer scanline_dimmer (
        .clk_logic_w(clk_logic_w),
        .reset_i(reset_i),
        .r_i(r_i),
        .g_i(g_i),
        .b_i(b_i),
        .screen_y_i(screen_y_i),
        .scanline_sw_n_i(dip_switches_n_i[0]),
        .r_o(r_o),
        .g_o(g_o),
        .b_o(b_o)
    );

endmodule

// File: tb_a2_card.sv
// ====================
// Self-checking testbench for the card glue top level
// Runs the vectors of the stimulus file, then random bus echoes
// ====================
`timescale 1ns/1ns

module tb_a2_card;

    import a2_card_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam int SETTLE_CYCLES = 8;
    localparam int RANDOM_VECTORS = 16;
    localparam int WAIT_LIMIT = 32;
    localparam int RUN_LIMIT_NS = 200000;
    localparam string STIM_FILE = "a2_card_stimulus.txt";

    logic clk_logic_w;
    logic reset_i;
    logic a2_phi1_i;
    logic a2_7m_i;
    logic [3:0] dip_switches_n_i;
    a2_data_t bus_data_i;
    logic ssc_rd_i;
    a2_data_t ssc_data_i;
    logic ssp_rd_i;
    a2_data_t ssp_data_i;
    logic mb_rd_i;
    a2_data_t mb_data_i;
    logic ssc_irq_n_i;
    logic ssp_irq_n_i;
    logic mb_irq_n_i;
    audio_sample_t ensoniq_l_i;
    audio_sample_t ensoniq_r_i;
    audio_sample_t ssp_audio_i;
    mb_level_t mb_l_i;
    mb_level_t mb_r_i;
    logic speaker_i;
    color_t r_i;
    color_t g_i;
    color_t b_i;
    screen_coord_t screen_y_i;

    logic phi0_o;
    logic phi1_o;
    logic phi1_posedge_o;
    logic phi1_negedge_o;
    logic clk_7m_o;
    logic clk_7m_posedge_o;
    logic clk_7m_negedge_o;
    logic data_out_en_o;
    a2_data_t data_out_o;
    logic irq_n_o;
    audio_sample_t mix_l_o;
    audio_sample_t mix_r_o;
    color_t r_o;
    color_t g_o;
    color_t b_o;

    // Fields of the current stimulus line
    logic [31:0] fld [0:12];
    string line;
    integer fd;
    integer rc;
    integer seed;
    int errors = 0;
    int vectors = 0;

    a2_card_top UUT (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;
    end

    // Hard limit on the whole run
    initial begin
        #(RUN_LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", RUN_LIMIT_NS);
        $display("Vectors checked: %0d, errors: %0d", vectors, errors);
        $display("Simulation failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, expected);
    endtask

    task automatic check_bus(input logic exp_en, input a2_data_t exp_data,
                             input logic exp_irq);
        // One cycle through the select register
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        vectors++;
        if (data_out_en_o !== exp_en)
            report_mismatch("data_out_en_o", 32'(data_out_en_o), 32'(exp_en));
        if (data_out_o !== exp_data)
            report_mismatch("data_out_o", 32'(data_out_o), 32'(exp_data));
        if (irq_n_o !== exp_irq)
            report_mismatch("irq_n_o", 32'(irq_n_o), 32'(exp_irq));
    endtask

    task automatic bus_vector();
        @(posedge clk_logic_w);
        ssc_rd_i <= fld[0][0];
        ssc_data_i <= fld[1][7:0];
        ssp_rd_i <= fld[2][0];
        ssp_data_i <= fld[3][7:0];
        mb_rd_i <= fld[4][0];
        mb_data_i <= fld[5][7:0];
        bus_data_i <= fld[6][7:0];
        ssc_irq_n_i <= fld[7][0];
        ssp_irq_n_i <= fld[8][0];
        mb_irq_n_i <= fld[9][0];
        check_bus(fld[10][0], fld[11][7:0], fld[12][0]);
    endtask

    task automatic random_bus_echo();
        logic [31:0] rnd;
        a2_data_t bus_byte;
        logic [2:0] irq_bits;
        for (int i = 0; i < RANDOM_VECTORS; i++) begin
            rnd = $random(seed);
            bus_byte = rnd[7:0];
            irq_bits = rnd[10:8];
            @(posedge clk_logic_w);
            ssc_rd_i <= 1'b0;
            ssp_rd_i <= 1'b0;
            mb_rd_i <= 1'b0;
            bus_data_i <= bus_byte;
            ssc_irq_n_i <= irq_bits[0];
            ssp_irq_n_i <= irq_bits[1];
            mb_irq_n_i <= irq_bits[2];
            // No card reads, so the bus byte comes back unchanged
            check_bus(1'b0, bus_byte, &irq_bits);
        end
    endtask

    task automatic audio_vector();
        @(posedge clk_logic_w);
        ensoniq_l_i <= fld[0][15:0];
        ensoniq_r_i <= fld[1][15:0];
        ssp_audio_i <= fld[2][15:0];
        mb_l_i <= fld[3][9:0];
        mb_r_i <= fld[4][9:0];
        speaker_i <= fld[5][0];
        dip_switches_n_i[1] <= fld[6][0];
        // Convert stage, then sum stage
        repeat (2) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        vectors++;
        if (mix_l_o !== fld[7][15:0])
            report_mismatch("mix_l_o", 32'(mix_l_o), fld[7]);
        if (mix_r_o !== fld[8][15:0])
            report_mismatch("mix_r_o", 32'(mix_r_o), fld[8]);
    endtask

    task automatic video_vector();
        @(posedge clk_logic_w);
        r_i <= fld[0][7:0];
        g_i <= fld[1][7:0];
        b_i <= fld[2][7:0];
        screen_y_i <= fld[3][9:0];
        dip_switches_n_i[0] <= fld[4][0];
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        vectors++;
        if (r_o !== fld[5][7:0])
            report_mismatch("r_o", 32'(r_o), fld[5]);
        if (g_o !== fld[6][7:0])
            report_mismatch("g_o", 32'(g_o), fld[6]);
        if (b_o !== fld[7][7:0])
            report_mismatch("b_o", 32'(b_o), fld[7]);
    endtask

    task automatic wait_phi1_low();
        int waited;
        waited = 0;
        while (phi1_o !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk_logic_w);
            waited++;
        end
        if (phi1_o !== 1'b0) begin
            errors++;
            $display("phi1_o did not return low within %0d cycles at t=%0t", WAIT_LIMIT, $time);
        end
    endtask

    task automatic phi1_pulse();
        int pos_count;
        int neg_count;
        int high_count;
        int pos_7m_count;
        int neg_7m_count;
        int high_7m_count;
        int exp_high;
        int total;
        pos_count = 0;
        neg_count = 0;
        high_count = 0;
        pos_7m_count = 0;
        neg_7m_count = 0;
        high_7m_count = 0;
        total = fld[0] + fld[1] + SETTLE_CYCLES;
        // Both edges have the same latency, so an accepted pulse keeps its width
        exp_high = (fld[2] != 0) ? int'(fld[0]) : 0;
        wait_phi1_low();
        // High for fld[0] cycles, then low for the rest of the window
        // The 7M input gets the same pulse
        for (int i = 0; i < total; i++) begin
            @(posedge clk_logic_w);
            a2_phi1_i <= (i < fld[0]);
            a2_7m_i <= (i < fld[0]);
            @(negedge clk_logic_w);
            if (phi1_posedge_o === 1'b1)
                pos_count++;
            if (phi1_negedge_o === 1'b1)
                neg_count++;
            if (phi1_o === 1'b1)
                high_count++;
            if (clk_7m_posedge_o === 1'b1)
                pos_7m_count++;
            if (clk_7m_negedge_o === 1'b1)
                neg_7m_count++;
            if (clk_7m_o === 1'b1)
                high_7m_count++;
            if (phi0_o !== ~phi1_o)
                report_mismatch("phi0_o", 32'(phi0_o), 32'(~phi1_o));
        end
        vectors++;
        if (pos_count != fld[2])
            report_mismatch("phi1_posedge_o count", pos_count, fld[2]);
        if (neg_count != fld[3])
            report_mismatch("phi1_negedge_o count", neg_count, fld[3]);
        if (high_count != exp_high)
            report_mismatch("phi1_o high cycles", high_count, exp_high);
        if (pos_7m_count != fld[2])
            report_mismatch("clk_7m_posedge_o count", pos_7m_count, fld[2]);
        if (neg_7m_count != fld[3])
            report_mismatch("clk_7m_negedge_o count", neg_7m_count, fld[3]);
        if (high_7m_count != exp_high)
            report_mismatch("clk_7m_o high cycles", high_7m_count, exp_high);
    endtask

    task automatic run_line();
        byte kind;
        string rest;
        int n;
        kind = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        n = 0;
        case (kind)
            "B": n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                             fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
            "A": n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                             fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
            "V": n = $sscanf(rest, "%h %h %h %h %h %h %h %h", fld[0], fld[1],
                             fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
            "P": n = $sscanf(rest, "%d %d %d %d", fld[0], fld[1], fld[2], fld[3]);
            default: n = -1;
        endcase
        if (kind == "B" && n == 13)
            bus_vector();
        else if (kind == "A" && n == 9)
            audio_vector();
        else if (kind == "V" && n == 8)
            video_vector();
        else if (kind == "P" && n == 4)
            phi1_pulse();
        else if (kind != "#" && kind != 8'h0a && kind != 8'h0d && kind != 8'h00) begin
            errors++;
            $display("Stimulus line could not be read: %s", line);
        end
    endtask

    initial begin
        seed = 32'h5d88;
        reset_i = 1'b1;
        a2_phi1_i = 1'b0;
        a2_7m_i = 1'b0;
        dip_switches_n_i = 4'b1111;
        bus_data_i = '0;
        ssc_rd_i = 1'b0;
        ssc_data_i = '0;
        ssp_rd_i = 1'b0;
        ssp_data_i = '0;
        mb_rd_i = 1'b0;
        mb_data_i = '0;
        ssc_irq_n_i = 1'b1;
        ssp_irq_n_i = 1'b1;
        mb_irq_n_i = 1'b1;
        ensoniq_l_i = '0;
        ensoniq_r_i = '0;
        ssp_audio_i = '0;
        mb_l_i = '0;
        mb_r_i = '0;
        speaker_i = 1'b0;
        r_i = '0;
        g_i = '0;
        b_i = '0;
        screen_y_i = '0;

        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        reset_i <= 1'b0;
        @(negedge clk_logic_w);
        if (data_out_en_o !== 1'b0)
            report_mismatch("data_out_en_o", 32'(data_out_en_o), 32'h0);
        if (irq_n_o !== 1'b1)
            report_mismatch("irq_n_o", 32'(irq_n_o), 32'h1);
        if (mix_l_o !== '0)
            report_mismatch("mix_l_o", 32'(mix_l_o), 32'h0);
        if (mix_r_o !== '0)
            report_mismatch("mix_r_o", 32'(mix_r_o), 32'h0);
        if ({r_o, g_o, b_o} !== '0)
            report_mismatch("r_o/g_o/b_o", 32'({r_o, g_o, b_o}), 32'h0);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0)
                    run_line();
            end
            $fclose(fd);
        end

        random_bus_echo();

        $display("Vectors checked: %0d, errors: %0d", vectors, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: a2_card_stimulus.txt
# One vector per line: kind letter, inputs, expected outputs; all hex except P lines
# Column layout of each kind is given in the comment above its group
# B ssc_rd ssc_d ssp_rd ssp_d mb_rd mb_d bus_d ssc_irq ssp_irq mb_irq exp_en exp_d exp_irq
B 1 a5 1 3c 1 77 00 1 1 1 1 a5 1
B 0 a5 1 3c 1 77 00 1 1 1 1 3c 1
B 0 a5 0 3c 1 77 00 1 1 1 1 77 1
B 0 a5 0 3c 0 77 e2 1 1 1 0 e2 1
B 1 11 0 22 1 33 44 0 1 1 1 11 0
B 0 11 1 22 0 33 44 1 0 1 1 22 0
B 0 11 0 22 0 33 5b 1 1 0 0 5b 0
B 1 c3 0 00 0 00 ff 1 1 1 1 c3 1
# A ens_l ens_r ssp mb_l mb_r speaker spk_sw_n exp_mix_l exp_mix_r
A 0000 0000 8000 200 200 0 1 c000 c000
A 1234 0100 9000 3ff 000 1 0 5214 c100
A 1234 0100 9000 3ff 000 0 0 f214 6100
A 1234 0100 9000 3ff 000 1 1 2214 9100
A ffff 8000 0000 100 2aa 0 1 1fff d540
A 7000 7000 ffff 3ff 3ff 1 0 1fdf 1fdf
# V r g b row scan_sw_n exp_r exp_g exp_b
V fe 81 40 001 0 7f 40 20
V fe 81 40 002 0 fe 81 40
V fe 81 40 001 1 fe 81 40
V ff ff ff 3ff 0 7f 7f 7f
V 01 02 03 0c7 0 00 01 01
V 01 02 03 0c7 1 01 02 03
# P high_cycles low_cycles exp_posedges exp_negedges (decimal)
P 3 6 1 1
P 1 6 0 0
P 2 6 0 0
P 5 8 1 1
P 4 4 1 1
P 2 3 0 0
P 10 3 1 1

// File: src.f
+incdir+.
a2_card_pkg.sv
a2_clock_sync.sv
bus_data_select.sv
audio_mixer.sv
scanline_dimmer.sv
a2_card_top.sv
tb_a2_card.sv

// File: Makefile
# Verilator build and run of the card glue testbench

VERILATOR ?= verilator
TOP ?= tb_a2_card
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Simulation failed
PASS_MSG ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := a2_card_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
